//--- verilog/Cpu6502Pkg.sv
// ****************************************
// 6502 execution slice definitions
// ****************************************

package Cpu6502Pkg;

// Data byte carried by registers, operands, results and opcodes
typedef logic [7:0] byte_t;

// Main ALU operation code
typedef logic [2:0] aluOp_t;

localparam aluOp_t ALU_OP_AND = 3'd0;
localparam aluOp_t ALU_OP_OR  = 3'd1;
localparam aluOp_t ALU_OP_EOR = 3'd2;
localparam aluOp_t ALU_OP_ADC = 3'd3;
localparam aluOp_t ALU_OP_SBC = 3'd4;
// Single operand group, the extension code picks the operation
localparam aluOp_t ALU_OP_SGL = 3'd5;

// Single operand extension code, only read when the main code is ALU_OP_SGL
typedef logic [2:0] aluSop_t;

localparam aluSop_t ALU_SOP_ASL    = 3'd0;
localparam aluSop_t ALU_SOP_LSR    = 3'd1;
localparam aluSop_t ALU_SOP_ROL    = 3'd2;
localparam aluSop_t ALU_SOP_ROR    = 3'd3;
// The test codes pass operand A through and pick one of its bits
localparam aluSop_t ALU_SOP_TEST_N = 3'd4;
localparam aluSop_t ALU_SOP_TEST_C = 3'd5;
localparam aluSop_t ALU_SOP_TEST_V = 3'd6;
localparam aluSop_t ALU_SOP_TEST_Z = 3'd7;

// Flag positions inside P
localparam int N_BIT_IN_P = 7;
localparam int V_BIT_IN_P = 6;
localparam int U_BIT_IN_P = 5;
localparam int D_BIT_IN_P = 3;
localparam int Z_BIT_IN_P = 1;
localparam int C_BIT_IN_P = 0;

// Unused bit 5 and I are set after reset
localparam byte_t STATUS_RESET = 8'h24;

// Register selector, REG_P reads P as an operand or writes no data register
typedef logic [1:0] regSel_t;

localparam regSel_t REG_A = 2'd0;
localparam regSel_t REG_X = 2'd1;
localparam regSel_t REG_Y = 2'd2;
localparam regSel_t REG_P = 2'd3;

// Source of ALU operand B
typedef logic [1:0] operandBSel_t;

localparam operandBSel_t OPB_IMM  = 2'd0;
localparam operandBSel_t OPB_ZERO = 2'd1;
localparam operandBSel_t OPB_ONE  = 2'd2;
localparam operandBSel_t OPB_ONES = 2'd3;

// Source of the ALU carry input
typedef logic [1:0] carrySel_t;

localparam carrySel_t CIN_FLAG = 2'd0;
localparam carrySel_t CIN_ZERO = 2'd1;
localparam carrySel_t CIN_ONE  = 2'd2;

// Mask aligned to P, one bit per flag
typedef logic [7:0] flagMask_t;

localparam flagMask_t FLAG_N = 8'h01 << N_BIT_IN_P;
localparam flagMask_t FLAG_V = 8'h01 << V_BIT_IN_P;
localparam flagMask_t FLAG_D = 8'h01 << D_BIT_IN_P;
localparam flagMask_t FLAG_Z = 8'h01 << Z_BIT_IN_P;
localparam flagMask_t FLAG_C = 8'h01 << C_BIT_IN_P;

endpackage

//--- verilog/Cpu6502Alu.sv
// ****************************************
// 6502 ALU
// ****************************************

module Cpu6502Alu (
    input  Cpu6502Pkg::byte_t   operandA,
    input  Cpu6502Pkg::byte_t   operandB,
    input  logic                carryIn,
    input  Cpu6502Pkg::aluOp_t  operation,
    input  Cpu6502Pkg::aluSop_t opExtension,
    input  logic                decimalMode,
    output Cpu6502Pkg::byte_t   result,
    output logic                carryOut,
    output logic                zero,
    output logic                negative,
    output logic                overflow,
    output logic                branchCondition
);

import Cpu6502Pkg::*;

// One nibble of the adder, returns {carry, digit}
// On subtract the addend is already inverted, so the raw sum carries past 15 exactly
// when the decimal difference needs no borrow, which is the same as "exceeds 9"
// in nines complement terms
function automatic logic [4:0] addNibble(
    input logic [3:0] addendA,
    input logic [3:0] addendB,
    input logic       carry,
    input logic       decimal,
    input logic       subtract
);
    logic [4:0] raw;
    logic       nibbleCarry;
    logic [3:0] digit;

    raw = {1'b0, addendA} + {1'b0, addendB} + {4'd0, carry};
    nibbleCarry = raw[4] | (decimal & ~subtract & (raw > 5'd9));
    digit = raw[3:0];
    // Decimal add skips the six unused codes once the digit wraps
    if (decimal && !subtract && nibbleCarry) begin
        digit = raw[3:0] + 4'd6;
    // A decimal borrow folds the digit back into 0..9
    end else if (decimal && subtract && !nibbleCarry) begin
        digit = raw[3:0] + 4'd10;
    end
    return {nibbleCarry, digit};
endfunction

logic       subtract;
byte_t      addendB;
logic [4:0] lowNibble;
logic [4:0] highNibble;
byte_t      sum;
logic       sumCarry;

// Subtract is an add of the one's complement, the carry input supplies the +1
assign subtract = (operation == ALU_OP_SBC);
assign addendB = subtract ? ~operandB : operandB;

// The low nibble carry ripples into the high nibble
assign lowNibble = addNibble(operandA[3:0], addendB[3:0], carryIn, decimalMode, subtract);
assign highNibble = addNibble(operandA[7:4], addendB[7:4], lowNibble[4], decimalMode,
                              subtract);
assign sum = {highNibble[3:0], lowNibble[3:0]};
assign sumCarry = highNibble[4];

// Z and N follow whatever the selected operation produced
assign zero = (result == 8'h00);
assign negative = result[7];

// Carry into bit 7 is a7 ^ b7 ^ s7, V is that compared with the carry out
// In decimal mode this uses the corrected sum, which is not NMOS exact
assign overflow = operandA[7] ^ addendB[7] ^ sum[7] ^ sumCarry;

always_comb begin
    // Most operations leave carry alone and never raise a branch condition
    result = operandA;
    carryOut = carryIn;
    branchCondition = 1'b0;

    case (operation)
        ALU_OP_AND: begin
            result = operandA & operandB;
        end

        ALU_OP_OR: begin
            result = operandA | operandB;
        end

        ALU_OP_EOR: begin
            result = operandA ^ operandB;
        end

        ALU_OP_ADC, ALU_OP_SBC: begin
            result = sum;
            carryOut = sumCarry;
        end

        ALU_OP_SGL: begin
            case (opExtension)
                ALU_SOP_ASL: begin
                    result = {operandA[6:0], 1'b0};
                    carryOut = operandA[7];
                end
                ALU_SOP_LSR: begin
                    result = {1'b0, operandA[7:1]};
                    carryOut = operandA[0];
                end
                ALU_SOP_ROL: begin
                    result = {operandA[6:0], carryIn};
                    carryOut = operandA[7];
                end
                ALU_SOP_ROR: begin
                    result = {carryIn, operandA[7:1]};
                    carryOut = operandA[0];
                end
                // Operand A holds P here, the chosen flag decides the branch
                ALU_SOP_TEST_N: branchCondition = operandA[N_BIT_IN_P];
                ALU_SOP_TEST_C: branchCondition = operandA[C_BIT_IN_P];
                ALU_SOP_TEST_V: branchCondition = operandA[V_BIT_IN_P];
                ALU_SOP_TEST_Z: branchCondition = operandA[Z_BIT_IN_P];
                default: branchCondition = 1'b0;
            endcase
        end

        // Unused codes pass operand A through
        default: begin
            result = operandA;
        end
    endcase
end

endmodule

//--- verilog/Cpu6502Decoder.sv
// ****************************************
// 6502 opcode decoder
// ****************************************

module Cpu6502Decoder (
    input  Cpu6502Pkg::byte_t        opcode,
    output Cpu6502Pkg::aluOp_t       operation,
    output Cpu6502Pkg::aluSop_t      opExtension,
    output Cpu6502Pkg::regSel_t      operandASel,
    output Cpu6502Pkg::operandBSel_t operandBSel,
    output Cpu6502Pkg::carrySel_t    carrySel,
    output logic                     decimalAllowed,
    output Cpu6502Pkg::regSel_t      destination,
    output Cpu6502Pkg::flagMask_t    flagMask,
    output Cpu6502Pkg::flagMask_t    flagSet,
    output Cpu6502Pkg::flagMask_t    flagClear,
    output logic                     isBranch,
    output logic                     branchSense,
    output logic                     legal
);

import Cpu6502Pkg::*;

// Bit 5 tells whether a branch is taken on a set or a clear flag
assign branchSense = opcode[5];

always_comb begin
    // Defaults describe an instruction that changes nothing
    operation = ALU_OP_OR;
    opExtension = ALU_SOP_ASL;
    operandASel = REG_A;
    operandBSel = OPB_ZERO;
    carrySel = CIN_FLAG;
    decimalAllowed = 1'b0;
    destination = REG_P;
    flagMask = '0;
    flagSet = '0;
    flagClear = '0;
    isBranch = 1'b0;
    legal = 1'b1;

    case (opcode)
        // Immediate arithmetic, the only group that honours D
        8'h69, 8'hE9: begin
            operation = opcode[7] ? ALU_OP_SBC : ALU_OP_ADC;
            operandBSel = OPB_IMM;
            decimalAllowed = 1'b1;
            destination = REG_A;
            flagMask = FLAG_N | FLAG_V | FLAG_Z | FLAG_C;
        end

        // Immediate logic ops
        8'h29: begin
            operation = ALU_OP_AND;
            operandBSel = OPB_IMM;
            destination = REG_A;
            flagMask = FLAG_N | FLAG_Z;
        end
        8'h09: begin
            operation = ALU_OP_OR;
            operandBSel = OPB_IMM;
            destination = REG_A;
            flagMask = FLAG_N | FLAG_Z;
        end
        8'h49: begin
            operation = ALU_OP_EOR;
            operandBSel = OPB_IMM;
            destination = REG_A;
            flagMask = FLAG_N | FLAG_Z;
        end

        // CMP is a binary subtract without borrow that keeps only the flags
        8'hC9: begin
            operation = ALU_OP_SBC;
            operandBSel = OPB_IMM;
            carrySel = CIN_ONE;
            flagMask = FLAG_N | FLAG_Z | FLAG_C;
        end

        // Accumulator shifts and rotates, bits 6:5 give ASL, ROL, LSR, ROR
        8'h0A, 8'h2A, 8'h4A, 8'h6A: begin
            operation = ALU_OP_SGL;
            opExtension = {1'b0, opcode[5], opcode[6]} == 3'd0 ? ALU_SOP_ASL :
                          {1'b0, opcode[5], opcode[6]} == 3'd1 ? ALU_SOP_LSR :
                          {1'b0, opcode[5], opcode[6]} == 3'd2 ? ALU_SOP_ROL : ALU_SOP_ROR;
            destination = REG_A;
            flagMask = FLAG_N | FLAG_Z | FLAG_C;
        end

        // Flag set and clear ops leave the ALU flags out entirely
        8'h18: flagClear = FLAG_C;
        8'h38: flagSet = FLAG_C;
        8'hD8: flagClear = FLAG_D;
        8'hF8: flagSet = FLAG_D;
        8'hB8: flagClear = FLAG_V;

        // Transfers are an OR with zero, so Z and N come out of the ALU
        8'hAA, 8'hA8: begin
            operandASel = REG_A;
            destination = opcode[1] ? REG_X : REG_Y;
            flagMask = FLAG_N | FLAG_Z;
        end
        8'h8A, 8'h98: begin
            operandASel = opcode[1] ? REG_X : REG_Y;
            destination = REG_A;
            flagMask = FLAG_N | FLAG_Z;
        end

        // Increments add one, decrements add all ones, both with carry in clear
        8'hE8, 8'hC8, 8'hCA, 8'h88: begin
            operation = ALU_OP_ADC;
            operandASel = (opcode == 8'hE8 || opcode == 8'hCA) ? REG_X : REG_Y;
            operandBSel = (opcode == 8'hE8 || opcode == 8'hC8) ? OPB_ONE : OPB_ONES;
            carrySel = CIN_ZERO;
            destination = operandASel;
            flagMask = FLAG_N | FLAG_Z;
        end

        // Branches test one bit of P, bits 7:6 pick N, V, C or Z
        8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: begin
            operation = ALU_OP_SGL;
            operandASel = REG_P;
            isBranch = 1'b1;
            case (opcode[7:6])
                2'd0: opExtension = ALU_SOP_TEST_N;
                2'd1: opExtension = ALU_SOP_TEST_V;
                2'd2: opExtension = ALU_SOP_TEST_C;
                default: opExtension = ALU_SOP_TEST_Z;
            endcase
        end

        default: legal = 1'b0;
    endcase
end

endmodule

//--- verilog/Cpu6502StatusRegister.sv
// ****************************************
// 6502 status register
// ****************************************

module Cpu6502StatusRegister (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  update,
    input  Cpu6502Pkg::flagMask_t flagMask,
    input  Cpu6502Pkg::flagMask_t flagSet,
    input  Cpu6502Pkg::flagMask_t flagClear,
    input  logic                  carry,
    input  logic                  zero,
    input  logic                  negative,
    input  logic                  overflow,
    output Cpu6502Pkg::byte_t     status
);

import Cpu6502Pkg::*;

byte_t aluFlags;
byte_t nextStatus;

always_comb begin
    // ALU flags laid out in P order so one mask selects them
    aluFlags = '0;
    aluFlags[N_BIT_IN_P] = negative;
    aluFlags[V_BIT_IN_P] = overflow;
    aluFlags[Z_BIT_IN_P] = zero;
    aluFlags[C_BIT_IN_P] = carry;

    // Masked bits take the ALU value, the rest hold
    nextStatus = (status & ~flagMask) | (aluFlags & flagMask);
    // Explicit set and clear come last
    nextStatus = (nextStatus | flagSet) & ~flagClear;
    // Bit 5 reads as one on a real part
    nextStatus[U_BIT_IN_P] = 1'b1;
end

always_ff @(posedge clk) begin
    if (reset) begin
        status <= STATUS_RESET;
    end else if (update) begin
        status <= nextStatus;
    end
end

endmodule

//--- verilog/Cpu6502RegisterFile.sv
// ****************************************
// 6502 data registers
// ****************************************

module Cpu6502RegisterFile (
    input  logic                clk,
    input  logic                reset,
    input  logic                write,
    input  Cpu6502Pkg::regSel_t destination,
    input  Cpu6502Pkg::byte_t   writeData,
    output Cpu6502Pkg::byte_t   accumulator,
    output Cpu6502Pkg::byte_t   indexX,
    output Cpu6502Pkg::byte_t   indexY
);

import Cpu6502Pkg::*;

// A, X and Y share one write port, the destination picks the register
always_ff @(posedge clk) begin
    if (reset) begin
        accumulator <= '0;
        indexX <= '0;
        indexY <= '0;
    end else if (write) begin
        case (destination)
            REG_A: accumulator <= writeData;
            REG_X: indexX <= writeData;
            REG_Y: indexY <= writeData;
            // REG_P as a destination means the result only feeds the flags
            default: begin
                accumulator <= accumulator;
            end
        endcase
    end
end

endmodule

//--- verilog/Cpu6502Execute.sv
// ****************************************
// 6502 execution slice
// ****************************************

module Cpu6502Execute (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  Cpu6502Pkg::byte_t opcode,
    input  Cpu6502Pkg::byte_t operand,
    output Cpu6502Pkg::byte_t accumulator,
    output Cpu6502Pkg::byte_t indexX,
    output Cpu6502Pkg::byte_t indexY,
    output Cpu6502Pkg::byte_t status,
    output logic              done,
    output logic              branchTaken,
    output logic              illegal
);

import Cpu6502Pkg::*;

aluOp_t       operation;
aluSop_t      opExtension;
regSel_t      operandASel;
operandBSel_t operandBSel;
carrySel_t    carrySel;
logic         decimalAllowed;
regSel_t      destination;
flagMask_t    flagMask;
flagMask_t    flagSet;
flagMask_t    flagClear;
logic         isBranch;
logic         branchSense;
logic         legal;
byte_t        aluOperandA;
byte_t        aluOperandB;
logic         aluCarryIn;
logic         aluDecimal;
byte_t        aluResult;
logic         aluCarry;
logic         aluZero;
logic         aluNegative;
logic         aluOverflow;
logic         branchCondition;
logic         commit;

Cpu6502Decoder decoder0 (
    .opcode         (opcode),
    .operation      (operation),
    .opExtension    (opExtension),
    .operandASel    (operandASel),
    .operandBSel    (operandBSel),
    .carrySel       (carrySel),
    .decimalAllowed (decimalAllowed),
    .destination    (destination),
    .flagMask       (flagMask),
    .flagSet        (flagSet),
    .flagClear      (flagClear),
    .isBranch       (isBranch),
    .branchSense    (branchSense),
    .legal          (legal)
);

// Operand A comes from a data register or from P for branch tests
always_comb begin
    case (operandASel)
        REG_A: aluOperandA = accumulator;
        REG_X: aluOperandA = indexX;
        REG_Y: aluOperandA = indexY;
        default: aluOperandA = status;
    endcase
end

// Operand B is the immediate byte or a constant for transfers and counting
always_comb begin
    case (operandBSel)
        OPB_IMM: aluOperandB = operand;
        OPB_ZERO: aluOperandB = 8'h00;
        OPB_ONE: aluOperandB = 8'h01;
        default: aluOperandB = 8'hFF;
    endcase
end

always_comb begin
    case (carrySel)
        CIN_FLAG: aluCarryIn = status[C_BIT_IN_P];
        CIN_ONE: aluCarryIn = 1'b1;
        default: aluCarryIn = 1'b0;
    endcase
end

// D only reaches the adder for ADC and SBC, so CMP and counting stay binary
assign aluDecimal = decimalAllowed & status[D_BIT_IN_P];

Cpu6502Alu alu0 (
    .operandA        (aluOperandA),
    .operandB        (aluOperandB),
    .carryIn         (aluCarryIn),
    .operation       (operation),
    .opExtension     (opExtension),
    .decimalMode     (aluDecimal),
    .result          (aluResult),
    .carryOut        (aluCarry),
    .zero            (aluZero),
    .negative        (aluNegative),
    .overflow        (aluOverflow),
    .branchCondition (branchCondition)
);

// An undecoded opcode still completes but changes no state
assign commit = issue & legal;

Cpu6502RegisterFile registers0 (
    .clk         (clk),
    .reset       (reset),
    .write       (commit),
    .destination (destination),
    .writeData   (aluResult),
    .accumulator (accumulator),
    .indexX      (indexX),
    .indexY      (indexY)
);

Cpu6502StatusRegister statusRegister0 (
    .clk       (clk),
    .reset     (reset),
    .update    (commit),
    .flagMask  (flagMask),
    .flagSet   (flagSet),
    .flagClear (flagClear),
    .carry     (aluCarry),
    .zero      (aluZero),
    .negative  (aluNegative),
    .overflow  (aluOverflow),
    .status    (status)
);

// Completion flags line up with the register writes one cycle after issue
always_ff @(posedge clk) begin
    if (reset) begin
        done <= 1'b0;
        branchTaken <= 1'b0;
        illegal <= 1'b0;
    end else begin
        done <= issue;
        illegal <= issue & ~legal;
        branchTaken <= commit & isBranch & (branchCondition == branchSense);
    end
end

endmodule

//--- testbench/Cpu6502ExecuteTb.sv
// ****************************************
// 6502 execution slice testbench
// ****************************************

module Cpu6502ExecuteTb;

timeunit 1ns;
timeprecision 100ps;

import Cpu6502Pkg::*;

// Test lengths, the watchdog budget is derived from them
localparam int BINARY_COUNT = 60;
localparam int DECIMAL_ROUNDS = 20;
localparam int MIXED_COUNT = 80;
localparam int BRANCH_ROUNDS = 4;
localparam int ILLEGAL_COUNT = 40;
localparam int TOTAL_INSTRUCTIONS = 1 + 2 * BINARY_COUNT + 1 + 4 * DECIMAL_ROUNDS + 5
                                    + MIXED_COUNT + 1 + 16 * BRANCH_ROUNDS + 2 * ILLEGAL_COUNT;
// Each test also spends a few idle cycles draining, plus reset and margin
localparam int TIMEOUT_NS = (TOTAL_INSTRUCTIONS + 6 * 4 + 8 + 200) * 8;

// Logic, shift, flag, transfer and counting opcodes, twenty in all
localparam logic [159:0] MIXED_OPS = {8'h29, 8'h09, 8'h49, 8'h0A, 8'h4A, 8'h2A, 8'h6A,
                                      8'h18, 8'h38, 8'hB8, 8'hD8, 8'hF8, 8'hAA, 8'hA8,
                                      8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88};

logic  clk;
logic  reset;
logic  issue;
byte_t opcode;
byte_t operand;
byte_t accumulator;
byte_t indexX;
byte_t indexY;
byte_t status;
logic  done;
logic  branchTaken;
logic  illegal;

// Model state and bookkeeping
byte_t       modelA;
byte_t       modelX;
byte_t       modelY;
byte_t       modelP;
logic [31:0] rngState;
logic [33:0] expectedQueue [$];
logic [33:0] expectedOutcome;
string       currentTest;
int          testErrors;
int          totalErrors;
int          testsPassed;
int          testsFailed;

Cpu6502Execute dut0 (
    .clk         (clk),
    .reset       (reset),
    .issue       (issue),
    .opcode      (opcode),
    .operand     (operand),
    .accumulator (accumulator),
    .indexX      (indexX),
    .indexY      (indexY),
    .status      (status),
    .done        (done),
    .branchTaken (branchTaken),
    .illegal     (illegal)
);

always #4 clk = ~clk;

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    state = state ^ (state << 13);
    state = state ^ (state >> 17);
    state = state ^ (state << 5);
    return state;
endfunction

// Nibble-wise adder, returns {overflow, carry, result}
// Subtract adds the inverted operand, a decimal digit carries above 9 on add
function automatic logic [9:0] addReference(
    input byte_t a,
    input byte_t b,
    input logic  carryIn,
    input logic  decimal,
    input logic  subtract
);
    byte_t      addend;
    byte_t      sum;
    logic [4:0] raw;
    logic       carry;

    addend = subtract ? ~b : b;
    carry = carryIn;
    for (int i = 0; i < 2; i++) begin
        raw = {1'b0, a[4 * i +: 4]} + {1'b0, addend[4 * i +: 4]} + {4'd0, carry};
        carry = (raw > 5'd15) || (decimal && !subtract && raw > 5'd9);
        if (decimal && !subtract && carry)
            raw = raw + 5'd6;
        else if (decimal && subtract && !carry)
            raw = raw + 5'd10;
        sum[4 * i +: 4] = raw[3:0];
    end
    return {a[7] ^ addend[7] ^ sum[7] ^ carry, carry, sum};
endfunction

// Returns {illegal, branchTaken, A, X, Y, P} after one instruction
function automatic logic [33:0] referenceStep(
    input byte_t op,
    input byte_t data,
    input byte_t a,
    input byte_t x,
    input byte_t y,
    input byte_t p
);
    logic [9:0] sumInfo;
    byte_t      flagSource;
    logic       updateNZ;
    logic       shiftOut;
    logic       selectedFlag;
    logic       taken;
    logic       unknown;

    updateNZ = 1'b1;
    taken = 1'b0;
    unknown = 1'b0;
    flagSource = 8'h00;
    case (op)
        8'h69, 8'hE9: begin
            // Only ADC and SBC see the D flag
            sumInfo = addReference(a, data, p[C_BIT_IN_P], p[D_BIT_IN_P], op == 8'hE9);
            a = sumInfo[7:0];
            p[C_BIT_IN_P] = sumInfo[8];
            p[V_BIT_IN_P] = sumInfo[9];
            flagSource = a;
        end
        8'hC9: begin
            sumInfo = addReference(a, data, 1'b1, 1'b0, 1'b1);
            p[C_BIT_IN_P] = sumInfo[8];
            flagSource = sumInfo[7:0];
        end
        8'h29, 8'h09, 8'h49: begin
            case (op)
                8'h29: a = a & data;
                8'h09: a = a | data;
                default: a = a ^ data;
            endcase
            flagSource = a;
        end
        8'h0A, 8'h2A: begin
            // ROL shifts the old carry in, ASL a zero
            shiftOut = a[7];
            a = {a[6:0], (op == 8'h2A) & p[C_BIT_IN_P]};
            p[C_BIT_IN_P] = shiftOut;
            flagSource = a;
        end
        8'h4A, 8'h6A: begin
            shiftOut = a[0];
            a = {(op == 8'h6A) & p[C_BIT_IN_P], a[7:1]};
            p[C_BIT_IN_P] = shiftOut;
            flagSource = a;
        end
        // Flag ops move only their own bit
        8'h18, 8'h38, 8'hD8, 8'hF8, 8'hB8: begin
            updateNZ = 1'b0;
            case (op)
                8'h18: p[C_BIT_IN_P] = 1'b0;
                8'h38: p[C_BIT_IN_P] = 1'b1;
                8'hD8: p[D_BIT_IN_P] = 1'b0;
                8'hF8: p[D_BIT_IN_P] = 1'b1;
                default: p[V_BIT_IN_P] = 1'b0;
            endcase
        end
        8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88: begin
            case (op)
                8'hAA: x = a;
                8'hA8: y = a;
                8'h8A: a = x;
                8'h98: a = y;
                8'hE8: x = x + 8'd1;
                8'hC8: y = y + 8'd1;
                8'hCA: x = x - 8'd1;
                default: y = y - 8'd1;
            endcase
            // N and Z follow the register that was written
            case (op)
                8'hAA, 8'hE8, 8'hCA: flagSource = x;
                8'hA8, 8'hC8, 8'h88: flagSource = y;
                default: flagSource = a;
            endcase
        end
        8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: begin
            // Bits 7:6 pick N, V, C or Z and bit 5 is the wanted value
            updateNZ = 1'b0;
            case (op[7:6])
                2'd0: selectedFlag = p[N_BIT_IN_P];
                2'd1: selectedFlag = p[V_BIT_IN_P];
                2'd2: selectedFlag = p[C_BIT_IN_P];
                default: selectedFlag = p[Z_BIT_IN_P];
            endcase
            taken = (selectedFlag == op[5]);
        end
        default: begin
            updateNZ = 1'b0;
            unknown = 1'b1;
        end
    endcase
    if (updateNZ) begin
        p[N_BIT_IN_P] = flagSource[7];
        p[Z_BIT_IN_P] = (flagSource == 8'h00);
    end
    return {unknown, taken, a, x, y, p};
endfunction

task automatic drawByte(output byte_t value);
    rngState = xorshift32(rngState);
    value = rngState[15:8];
endtask

// Two random decimal digits
task automatic drawBcd(output byte_t value);
    byte_t      raw;
    logic [3:0] high;
    logic [3:0] low;

    drawByte(raw);
    high = raw[7:4] % 10;
    low = raw[3:0] % 10;
    value = {high, low};
endtask

// Called on a falling edge, returns on the next one
task automatic issueInstruction(input byte_t op, input byte_t data);
    logic [33:0] outcome;

    outcome = referenceStep(op, data, modelA, modelX, modelY, modelP);
    {modelA, modelX, modelY, modelP} = outcome[31:0];
    expectedQueue.push_back(outcome);
    issue = 1'b1;
    opcode = op;
    operand = data;
    @(negedge clk);
    issue = 1'b0;
endtask

task automatic compareValue(input string what, input byte_t expected, input byte_t actual);
    assert (actual === expected) else begin
        $display("FAILED %s %s: expected %h, actual %h", currentTest, what, expected, actual);
        testErrors++;
    end
endtask

// Called on a rising edge, returns on the falling edge where stimulus starts
task automatic startTest(input string name);
    currentTest = name;
    testErrors = 0;
    @(negedge clk);
endtask

// Waits until every outstanding done has been checked, then reports on the rising edge
task automatic finishTest();
    while (expectedQueue.size() != 0) begin
        @(negedge clk);
    end
    @(posedge clk);
    if (testErrors == 0) begin
        testsPassed++;
        $display("Test %s: ok", currentTest);
    end else begin
        testsFailed++;
        $display("Test %s: %0d errors", currentTest, testErrors);
    end
    totalErrors += testErrors;
endtask

// Outputs settle after the rising edge, so they are checked on the falling one
always @(negedge clk) begin
    if (!reset) begin
        if (done) begin
            assert (expectedQueue.size() != 0) else begin
                $display("Error in %s: done pulsed with no instruction issued", currentTest);
                testErrors++;
            end
            if (expectedQueue.size() != 0) begin
                expectedOutcome = expectedQueue.pop_front();
                compareValue("illegal", {7'd0, expectedOutcome[33]}, {7'd0, illegal});
                compareValue("branchTaken", {7'd0, expectedOutcome[32]}, {7'd0, branchTaken});
                compareValue("accumulator", expectedOutcome[31:24], accumulator);
                compareValue("indexX", expectedOutcome[23:16], indexX);
                compareValue("indexY", expectedOutcome[15:8], indexY);
                compareValue("status", expectedOutcome[7:0], status);
            end
        end else begin
            assert (!branchTaken && !illegal) else begin
                $display("Error in %s: branchTaken or illegal high while done is low",
                         currentTest);
                testErrors++;
            end
        end
    end
end

// Watchdog
initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, instructions stopped completing", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
end

initial begin
    byte_t       sel;
    byte_t       data;
    byte_t       bcdA;
    byte_t       bcdB;
    byte_t       op;
    logic [33:0] probe;

    clk = 1'b0;
    reset = 1'b1;
    issue = 1'b0;
    opcode = 8'h00;
    operand = 8'h00;
    rngState = 32'd40;
    modelA = 8'h00;
    modelX = 8'h00;
    modelY = 8'h00;
    modelP = 8'h24;
    testErrors = 0;
    totalErrors = 0;
    testsPassed = 0;
    testsFailed = 0;

    // Reset stays high over four rising edges
    repeat (4) @(posedge clk);
    startTest("reset values");
    reset = 1'b0;
    compareValue("accumulator", 8'h00, accumulator);
    compareValue("indexX", 8'h00, indexX);
    compareValue("indexY", 8'h00, indexY);
    compareValue("status", 8'h24, status);
    compareValue("done", 8'h00, {7'd0, done});
    compareValue("branchTaken", 8'h00, {7'd0, branchTaken});
    compareValue("illegal", 8'h00, {7'd0, illegal});
    finishTest();

    // Each arithmetic op follows a random carry setup, EOR scrambles A now and then
    startTest("binary arithmetic");
    issueInstruction(8'hD8, 8'h00);
    for (int i = 0; i < BINARY_COUNT; i++) begin
        drawByte(sel);
        drawByte(data);
        issueInstruction(sel[1] ? 8'h38 : 8'h18, 8'h00);
        case (sel[3:2])
            2'd0: issueInstruction(8'h69, data);
            2'd1: issueInstruction(8'hE9, data);
            2'd2: issueInstruction(8'hC9, data);
            default: issueInstruction(8'h49, data);
        endcase
    end
    finishTest();

    // A is loaded with a BCD value through AND and ORA before every add or subtract
    startTest("decimal arithmetic");
    issueInstruction(8'hF8, 8'h00);
    for (int i = 0; i < DECIMAL_ROUNDS; i++) begin
        drawBcd(bcdA);
        drawBcd(bcdB);
        drawByte(sel);
        issueInstruction(8'h29, 8'h00);
        issueInstruction(8'h09, bcdA);
        issueInstruction(sel[0] ? 8'h38 : 8'h18, 8'h00);
        issueInstruction(sel[1] ? 8'hE9 : 8'h69, bcdB);
    end
    // After CLD 09 plus 01 must give the binary 0A
    issueInstruction(8'hD8, 8'h00);
    issueInstruction(8'h29, 8'h00);
    issueInstruction(8'h09, 8'h09);
    issueInstruction(8'h18, 8'h00);
    issueInstruction(8'h69, 8'h01);
    finishTest();

    startTest("logic shift transfer count");
    for (int i = 0; i < MIXED_COUNT; i++) begin
        drawByte(sel);
        drawByte(data);
        issueInstruction(MIXED_OPS[8 * (sel % 20) +: 8], data);
    end
    issueInstruction(8'hD8, 8'h00);
    finishTest();

    // Every branch follows a flag setter, AND #00 makes sure Z gets set too
    startTest("branches");
    for (int round = 0; round < BRANCH_ROUNDS; round++) begin
        for (int b = 0; b < 8; b++) begin
            drawByte(sel);
            drawByte(data);
            case (sel[1:0])
                2'd0: issueInstruction(8'h69, data);
                2'd1: issueInstruction(8'hE9, data);
                2'd2: issueInstruction(8'h29, data & {8{sel[2]}});
                default: issueInstruction(8'hB8, 8'h00);
            endcase
            issueInstruction(8'h10 + 8'(b * 32), 8'h00);
        end
    end
    finishTest();

    // Undecoded opcodes run back to back with legal ones
    startTest("illegal opcodes");
    for (int i = 0; i < ILLEGAL_COUNT; i++) begin
        drawByte(op);
        probe = referenceStep(op, 8'h00, modelA, modelX, modelY, modelP);
        while (!probe[33]) begin
            drawByte(op);
            probe = referenceStep(op, 8'h00, modelA, modelX, modelY, modelP);
        end
        drawByte(data);
        issueInstruction(op, data);
        drawByte(sel);
        issueInstruction(MIXED_OPS[8 * (sel % 20) +: 8], data);
    end
    finishTest();

    $display("Tests run %0d, ok %0d, with errors %0d, check errors %0d",
             testsPassed + testsFailed, testsPassed, testsFailed, totalErrors);
    if (testsFailed == 0 && totalErrors == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule

//--- Cpu6502Execute.f
verilog/Cpu6502Pkg.sv
verilog/Cpu6502Alu.sv
verilog/Cpu6502Decoder.sv
verilog/Cpu6502StatusRegister.sv
verilog/Cpu6502RegisterFile.sv
verilog/Cpu6502Execute.sv
testbench/Cpu6502ExecuteTb.sv
